/* hw/time_cfg.svh */
`ifndef TIME_CFG_SVH
`define TIME_CFG_SVH

// ############################################################
// Settings-bus placement of the time block
// ############################################################

`define TIME_REG_BASE 0

// Register offsets relative to the block base.
`define TIME_REG_NEXT_SECS  0
`define TIME_REG_NEXT_TICKS 1
`define TIME_REG_PPS_CTRL   2
`define TIME_REG_PPS_IMM    3

// ############################################################
// Time base
// ############################################################

`define TIME_TICKS_PER_SEC_DEFAULT 100000000

`endif

/* hw/settings_pkg.sv */
`default_nettype none

package settings_pkg;

   // ############################################################
   // Write-only strobe/address/data settings bus
   // ############################################################

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef logic [SET_ADDR_W-1:0] set_addr_t;  // Register address.
   typedef logic [SET_DATA_W-1:0] set_data_t;  // Write data.

endpackage

`default_nettype wire

/* hw/time_pkg.sv */
`default_nettype none

package time_pkg;

   // ############################################################
   // VITA-49 style time of day
   // ############################################################

   localparam int SECS_W  = 32;
   localparam int TICKS_W = 32;

   typedef logic [SECS_W-1:0]  seconds_t;   // Whole seconds.
   typedef logic [TICKS_W-1:0] ticks_t;     // Ticks within the second.

   // Seconds sit in the upper half, ticks in the lower half.
   typedef logic [SECS_W+TICKS_W-1:0] vita_time_t;

endpackage

`default_nettype wire

/* hw/time_ctrl_if.sv */
`default_nettype none

interface time_ctrl_if;

   time_pkg::seconds_t next_secs;      // Seconds preset.
   time_pkg::ticks_t   next_ticks;     // Ticks preset.
   logic               arm;            // Pulse after a seconds preset write.
   logic               imm_mode;       // Load without waiting for PPS.
   logic               pps_polarity;   // 1 samples PPS on the rising clock edge.
   logic               pps_source;     // 0 is SMA, 1 is MIMO.

   modport regs (
      output next_secs,
      output next_ticks,
      output arm,
      output imm_mode,
      output pps_polarity,
      output pps_source
   );

   modport sync (
      input pps_polarity,
      input pps_source
   );

   modport counter (
      input next_secs,
      input next_ticks,
      input arm,
      input imm_mode
   );

endinterface

`default_nettype wire

/* hw/time_regs.sv */
`default_nettype none

`include "time_cfg.svh"

module time_regs #(
   parameter int unsigned reg_base = `TIME_REG_BASE
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    set_stb,
   input  settings_pkg::set_addr_t set_addr,
   input  settings_pkg::set_data_t set_data,
   time_ctrl_if.regs               ctrl
);

   // ############################################################
   // Address decode
   // ############################################################

   localparam settings_pkg::set_addr_t secs_addr =
      settings_pkg::set_addr_t'(reg_base + `TIME_REG_NEXT_SECS);
   localparam settings_pkg::set_addr_t ticks_addr =
      settings_pkg::set_addr_t'(reg_base + `TIME_REG_NEXT_TICKS);
   localparam settings_pkg::set_addr_t ctrl_addr =
      settings_pkg::set_addr_t'(reg_base + `TIME_REG_PPS_CTRL);
   localparam settings_pkg::set_addr_t imm_addr =
      settings_pkg::set_addr_t'(reg_base + `TIME_REG_PPS_IMM);

   logic secs_wr;
   logic ticks_wr;
   logic ctrl_wr;
   logic imm_wr;

   assign secs_wr  = set_stb && (set_addr == secs_addr);
   assign ticks_wr = set_stb && (set_addr == ticks_addr);
   assign ctrl_wr  = set_stb && (set_addr == ctrl_addr);
   assign imm_wr   = set_stb && (set_addr == imm_addr);   // Other addresses fall through.

   // ############################################################
   // Preset and control registers
   // ############################################################

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ctrl.next_secs    <= '0;
         ctrl.next_ticks   <= '0;
         ctrl.arm          <= 1'b0;
         ctrl.imm_mode     <= 1'b0;
         ctrl.pps_polarity <= 1'b0;
         ctrl.pps_source   <= 1'b0;
      end
      else
      begin
         ctrl.arm <= secs_wr;
         if (secs_wr)
            ctrl.next_secs <= set_data;
         if (ticks_wr)
            ctrl.next_ticks <= set_data;
         if (ctrl_wr)
         begin
            ctrl.pps_polarity <= set_data[0];
            ctrl.pps_source   <= set_data[1];
         end
         if (imm_wr)
            ctrl.imm_mode <= set_data[0];   // Bit 0 selects immediate loading.
      end
   end

   // The arm request is a single-cycle pulse seen by the counter.
   a_arm_pulse : assert property (
      @(posedge clk) disable iff (rst)
      ctrl.arm |=> !ctrl.arm
   );

endmodule

`default_nettype wire

/* hw/pps_sync.sv */
`default_nettype none

module pps_sync (
   input  logic      clk,
   input  logic      rst,
   input  logic      pps_sma,
   input  logic      pps_mimo,
   time_ctrl_if.sync ctrl,
   output logic      pps_edge
);

   logic       pps_sel;    // Selected PPS input.
   logic       pps_pos;    // Sampled on the rising clock edge.
   logic       pps_neg;    // Sampled on the falling clock edge.
   logic       pps_pick;
   logic [1:0] pps_del;

   // ############################################################
   // Source select and edge-specific sampling
   // ############################################################

   assign pps_sel = ctrl.pps_source ? pps_mimo : pps_sma;

   always_ff @(posedge clk)
   begin
      pps_pos <= pps_sel;
   end

   always_ff @(negedge clk)
   begin
      pps_neg <= pps_sel;
   end

   assign pps_pick = ctrl.pps_polarity ? pps_pos : pps_neg;

   // ############################################################
   // Synchronizer and rising-edge detect
   // ############################################################

   always_ff @(posedge clk)
   begin
      if (rst)
         pps_del <= 2'b00;
      else
         pps_del <= {pps_del[0], pps_pick};
   end

   // High for one cycle per rising PPS transition.
   assign pps_edge = pps_del[0] & ~pps_del[1];

   a_edge_single : assert property (
      @(posedge clk) disable iff (rst)
      pps_edge |=> !pps_edge
   );

endmodule

`default_nettype wire

/* hw/time_counter.sv */
`default_nettype none

`include "time_cfg.svh"

module time_counter #(
   parameter int unsigned ticks_per_sec = `TIME_TICKS_PER_SEC_DEFAULT
) (
   input  logic                clk,
   input  logic                rst,
   time_ctrl_if.counter        ctrl,
   input  logic                pps_edge,
   output time_pkg::vita_time_t vita_time
);

   // Last tick value before the second rolls over.
   localparam time_pkg::ticks_t rollover = time_pkg::ticks_t'(ticks_per_sec - 1);

   time_pkg::seconds_t seconds;
   time_pkg::ticks_t   ticks;
   logic               armed;   // A preset is waiting to be loaded.
   logic               load;

   // ############################################################
   // Armed preset loading
   // ############################################################

   assign load = armed & (ctrl.imm_mode | pps_edge);

   always_ff @(posedge clk)
   begin
      if (rst)
         armed <= 1'b0;
      else if (ctrl.arm)
         armed <= 1'b1;   // A fresh request wins over a load at the same edge.
      else if (load)
         armed <= 1'b0;
   end

   // ############################################################
   // Seconds and ticks
   // ############################################################

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         seconds <= '0;
         ticks   <= '0;
      end
      else if (load)
      begin
         seconds <= ctrl.next_secs;
         ticks   <= ctrl.next_ticks;
      end
      else if (ticks == rollover)
      begin
         seconds <= seconds + 1'b1;
         ticks   <= '0;
      end
      else
      begin
         ticks <= ticks + 1'b1;
      end
   end

   assign vita_time = {seconds, ticks};

   // Presets out of range would break the rollover, so the tick count is watched.
   a_ticks_range : assert property (
      @(posedge clk) disable iff (rst)
      ticks < ticks_per_sec
   );

endmodule

`default_nettype wire

/* hw/vita_timer.sv */
`default_nettype none

`include "time_cfg.svh"

module vita_timer #(
   parameter int unsigned ticks_per_sec = `TIME_TICKS_PER_SEC_DEFAULT,
   parameter int unsigned reg_base      = `TIME_REG_BASE
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    set_stb,
   input  settings_pkg::set_addr_t set_addr,
   input  settings_pkg::set_data_t set_data,
   input  logic                    pps_sma,
   input  logic                    pps_mimo,
   output time_pkg::vita_time_t    vita_time,
   output logic                    pps_int
);

   // ############################################################
   // Internal connections
   // ############################################################

   time_ctrl_if ctrl ();

   logic pps_edge;   // Synchronized PPS rising edge.

   // ############################################################
   // Register block, PPS synchronizer and time counter
   // ############################################################

   time_regs #(
      .reg_base (reg_base)
   ) i_time_regs (
      .clk      (clk),
      .rst      (rst),
      .set_stb  (set_stb),
      .set_addr (set_addr),
      .set_data (set_data),
      .ctrl     (ctrl.regs)
   );

   pps_sync i_pps_sync (
      .clk      (clk),
      .rst      (rst),
      .pps_sma  (pps_sma),
      .pps_mimo (pps_mimo),
      .ctrl     (ctrl.sync),
      .pps_edge (pps_edge)
   );

   time_counter #(
      .ticks_per_sec (ticks_per_sec)
   ) i_time_counter (
      .clk       (clk),
      .rst       (rst),
      .ctrl      (ctrl.counter),
      .pps_edge  (pps_edge),
      .vita_time (vita_time)
   );

   // The detected edge doubles as the host interrupt.
   assign pps_int = pps_edge;

endmodule

`default_nettype wire

/* tests/tb_vita_timer.sv */
`default_nettype none

`include "time_cfg.svh"

module tb_vita_timer;

   localparam int unsigned ticks_per_sec = 50;
   localparam int          max_cycles    = 4000;

   localparam settings_pkg::set_addr_t secs_addr =
      settings_pkg::set_addr_t'(`TIME_REG_BASE + `TIME_REG_NEXT_SECS);
   localparam settings_pkg::set_addr_t ticks_addr =
      settings_pkg::set_addr_t'(`TIME_REG_BASE + `TIME_REG_NEXT_TICKS);
   localparam settings_pkg::set_addr_t ctrl_addr =
      settings_pkg::set_addr_t'(`TIME_REG_BASE + `TIME_REG_PPS_CTRL);
   localparam settings_pkg::set_addr_t imm_addr =
      settings_pkg::set_addr_t'(`TIME_REG_BASE + `TIME_REG_PPS_IMM);

   logic                    clk;
   logic                    rst;
   logic                    set_stb;
   settings_pkg::set_addr_t set_addr;
   settings_pkg::set_data_t set_data;
   logic                    pps_sma;
   logic                    pps_mimo;
   time_pkg::vita_time_t    vita_time;
   logic                    pps_int;

   // Reference model state.
   time_pkg::seconds_t   m_secs;
   time_pkg::ticks_t     m_ticks;
   time_pkg::seconds_t   m_next_secs;
   time_pkg::ticks_t     m_next_ticks;
   logic                 m_arm;
   logic                 m_armed;
   logic                 m_imm;
   logic                 m_source;
   logic                 m_load;
   logic                 secs_wr;
   logic                 int_seen;   // The pps_int level of the last cycle.
   logic                 sel_pps;
   logic                 sel_prev;
   time_pkg::vita_time_t exp_time;
   time_pkg::vita_time_t exp_preset;

   int          rise_age;      // Edges since the last selected PPS rise.
   int          pulse_count;   // Interrupts seen since that rise.
   int          write_age;     // Edges since the last seconds preset write.
   int          errors = 0;
   int          cycles = 0;
   int unsigned rng_state = 8;
   string       test_name = "reset";

   vita_timer #(
      .ticks_per_sec (ticks_per_sec)
   ) i_vita_timer (
      .clk       (clk),
      .rst       (rst),
      .set_stb   (set_stb),
      .set_addr  (set_addr),
      .set_data  (set_data),
      .pps_sma   (pps_sma),
      .pps_mimo  (pps_mimo),
      .vita_time (vita_time),
      .pps_int   (pps_int)
   );

   always #10 clk = ~clk;

   // ############################################################
   // Reference model
   // ############################################################

   assign secs_wr    = set_stb && (set_addr == secs_addr);
   assign m_load     = m_armed && (m_imm || int_seen);
   assign sel_pps    = m_source ? pps_mimo : pps_sma;
   assign exp_time   = {m_secs, m_ticks};
   assign exp_preset = {m_next_secs, m_next_ticks};

   always @(negedge clk)
   begin
      int_seen <= pps_int;
   end

   always @(posedge clk)
   begin
      if (rst)
      begin
         m_secs       <= '0;
         m_ticks      <= '0;
         m_next_secs  <= '0;
         m_next_ticks <= '0;
         m_arm        <= 1'b0;
         m_armed      <= 1'b0;
         m_imm        <= 1'b0;
         m_source     <= 1'b0;
      end
      else
      begin
         m_arm <= secs_wr;
         if (secs_wr)
            m_next_secs <= set_data;
         if (set_stb && (set_addr == ticks_addr))
            m_next_ticks <= set_data;
         if (set_stb && (set_addr == ctrl_addr))
            m_source <= set_data[1];
         if (set_stb && (set_addr == imm_addr))
            m_imm <= set_data[0];
         if (m_arm)
            m_armed <= 1'b1;
         else if (m_load)
            m_armed <= 1'b0;
         if (m_load)
         begin
            m_secs  <= m_next_secs;
            m_ticks <= m_next_ticks;
         end
         else if (m_ticks == ticks_per_sec - 1)
         begin
            m_secs  <= m_secs + 32'd1;
            m_ticks <= '0;
         end
         else
            m_ticks <= m_ticks + 32'd1;
      end
   end

   // Ages of the last PPS rise and the last seconds write.
   always @(posedge clk)
   begin
      if (rst)
      begin
         rise_age    <= 100;
         pulse_count <= 1;
         write_age   <= 100;
         sel_prev    <= 1'b0;
      end
      else
      begin
         sel_prev <= sel_pps;
         if (sel_pps && !sel_prev)
         begin
            rise_age    <= 1;
            pulse_count <= 0;
         end
         else
         begin
            if (rise_age < 100)
               rise_age <= rise_age + 1;
            if (int_seen)
               pulse_count <= pulse_count + 1;
         end
         if (secs_wr)
            write_age <= 1;
         else if (write_age < 100)
            write_age <= write_age + 1;
      end
   end

   // ############################################################
   // Checks
   // ############################################################

   a_time : assert property (@(posedge clk) disable iff (rst) vita_time == exp_time)
   else
   begin
      errors = errors + 1;
      $display("Fail %s expected %h actual %h", test_name, $sampled(exp_time),
               $sampled(vita_time));
   end

   a_imm_load : assert property (@(posedge clk) disable iff (rst)
      (write_age == 3 && m_imm) |-> vita_time == exp_preset)
   else
   begin
      errors = errors + 1;
      $display("Fail %s expected %h actual %h", test_name, $sampled(exp_preset),
               $sampled(vita_time));
   end

   a_pps_load : assert property (@(posedge clk) disable iff (rst)
      $past(pps_int && m_armed) |-> vita_time == exp_preset)
   else
   begin
      errors = errors + 1;
      $display("Fail %s expected %h actual %h", test_name, $sampled(exp_preset),
               $sampled(vita_time));
   end

   a_pps_window : assert property (@(posedge clk) disable iff (rst)
      pps_int |-> (rise_age >= 1 && rise_age <= 3 && pulse_count == 0))
   else
   begin
      errors = errors + 1;
      $display("In %s an interrupt came without a matching PPS rise.", test_name);
   end

   a_pps_missing : assert property (@(posedge clk) disable iff (rst)
      (rise_age == 3 && pulse_count == 0) |-> pps_int)
   else
   begin
      errors = errors + 1;
      $display("In %s a PPS rise gave no interrupt within three cycles.", test_name);
   end

   // ############################################################
   // Stimulus
   // ############################################################

   function automatic int unsigned next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state >> 8;
   endfunction

   task automatic write_reg(input settings_pkg::set_addr_t addr,
                            input settings_pkg::set_data_t data);
      @(posedge clk);
      set_stb  <= 1'b1;
      set_addr <= addr;
      set_data <= data;
      @(posedge clk);
      set_stb <= 1'b0;
   endtask

   task automatic write_preset();
      int unsigned secs;
      int unsigned ticks;
      secs  = (next_rand() << 8) ^ next_rand();
      ticks = next_rand() % ticks_per_sec;   // Presets stay inside one second.
      write_reg(ticks_addr, ticks);
      write_reg(secs_addr, secs);
   endtask

   task automatic pulse_pps(input logic on_mimo);
      int unsigned gap;
      gap = 20 + next_rand() % 30;
      @(posedge clk);
      if (on_mimo)
         pps_mimo <= 1'b1;
      else
         pps_sma <= 1'b1;
      repeat (6) @(posedge clk);
      pps_mimo <= 1'b0;
      pps_sma  <= 1'b0;
      repeat (gap) @(posedge clk);
   endtask

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("Timeout after %0d cycles with %0d errors.", max_cycles, errors);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial
   begin
      clk      = 1'b0;
      rst      = 1'b1;
      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      pps_sma  = 1'b0;
      pps_mimo = 1'b0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;

      test_name = "free_run";
      repeat (160) @(posedge clk);

      test_name = "pps_pulse";
      repeat (3) pulse_pps(1'b0);
      write_reg(ctrl_addr, 32'h1);
      repeat (3) pulse_pps(1'b0);

      test_name = "source_select";
      repeat (3) pulse_pps(1'b1);
      write_reg(ctrl_addr, 32'h3);
      repeat (3) pulse_pps(1'b1);
      repeat (3) pulse_pps(1'b0);
      write_reg(ctrl_addr, 32'h2);
      repeat (2) pulse_pps(1'b1);

      test_name = "pps_load";
      write_reg(ctrl_addr, 32'h1);
      repeat (2)
      begin
         write_preset();
         repeat (20 + next_rand() % 20) @(posedge clk);
         pulse_pps(1'b0);
         repeat (60) @(posedge clk);
         pulse_pps(1'b0);   // Nothing is armed here.
      end

      test_name = "imm_load";
      write_reg(imm_addr, 32'h1);
      repeat (3)
      begin
         write_preset();
         repeat (10) @(posedge clk);
      end
      pulse_pps(1'b0);
      write_reg(imm_addr, 32'h0);

      test_name = "addr_decode";
      write_reg(ticks_addr, next_rand() % ticks_per_sec);
      write_reg(8'h04, next_rand() | 32'h1);
      write_reg(8'h07, next_rand() | 32'h1);
      write_reg(8'h80, next_rand() | 32'h1);
      write_reg(8'hff, next_rand() | 32'h1);
      write_reg(secs_addr, next_rand());
      repeat (10) @(posedge clk);
      pulse_pps(1'b0);
      repeat (20) @(posedge clk);

      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/settings_pkg.sv
hw/time_pkg.sv
hw/time_ctrl_if.sv
hw/time_regs.sv
hw/pps_sync.sv
hw/time_counter.sv
hw/vita_timer.sv
tests/tb_vita_timer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the VITA timer testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_vita_timer \
   -f files.f \
   --Mdir obj_dir \
   -o sim_vita_timer

./obj_dir/sim_vita_timer 2>&1 | tee "$log"

if grep -qF "*** FAILED ***" "$log"; then
   echo "Simulation reported errors, see $log."
   exit 1
fi

echo "Simulation finished without errors."
exit 0
